// File: cam_pkg.sv
`default_nettype none

package cam_pkg;

    // Image geometry, pixels per µblock and µblocks per image
    localparam int pix_cols_per_block  = 8;
    localparam int pix_lines_per_block = 16;
    localparam int block_cols          = 5;
    localparam int block_lines         = 3;

    // Also the divisor of the block average
    localparam int pixels_per_block = pix_cols_per_block * pix_lines_per_block;

    // Word as the sensor delivers it on pclk
    typedef struct packed {
        logic [23:0] rgb;
        logic        hsync;
        logic        vsync;
    } cam_word_t;

    // Reordered pixel with its place in the µblock grid
    typedef struct packed {
        logic [23:0] data;
        logic        valid;
        logic [2:0]  pixel_col;
        logic [3:0]  pixel_line;
        logic [2:0]  block_col;
        logic [1:0]  block_line;
    } pixel_t;

    // One averaged colour, same byte order as pixel_t data
    typedef struct packed {
        logic [23:0] avg;
        logic [2:0]  block_col;
        logic [1:0]  block_line;
    } block_avg_t;

endpackage

`default_nettype wire

// File: pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
    // Power of two, at least 4
    parameter int fifo_depth = 16
) (
    input  logic               pclk,
    input  logic               clk,
    input  logic               nrst,

    input  logic               push,
    input  cam_pkg::cam_word_t wr_word,

    output cam_pkg::cam_word_t rd_word,
    output logic               empty,
    output logic               overflow
);

    localparam int aw = $clog2(fifo_depth);

    // fifo_depth at pointer width
    localparam logic [aw:0] depth_cnt = {1'b1, {aw{1'b0}}};

    cam_pkg::cam_word_t mem [fifo_depth];

    // Pointers carry one extra bit to tell full from empty
    logic [aw:0] wr_bin;
    logic [aw:0] wr_gray;
    logic [aw:0] wr_bin_next;
    logic [aw:0] rd_bin;
    logic [aw:0] rd_gray;
    logic [aw:0] rd_bin_next;

    // Gray pointers seen from the other domain
    logic [aw:0] rd_gray_w1;
    logic [aw:0] rd_gray_w2;
    logic [aw:0] wr_gray_r1;
    logic [aw:0] wr_gray_r2;

    logic full;
    logic wr_en;

    // Binary views of the synchronised Gray pointers
    logic [aw:0] rd_bin_w;
    logic [aw:0] wr_bin_r;
    logic [aw:0] wr_used;
    logic [aw:0] rd_used;

    assign wr_bin_next = wr_bin + 1'b1;
    assign rd_bin_next = rd_bin + 1'b1;

    // Full when the top two Gray bits differ and the rest match
    assign full  = (wr_gray == {~rd_gray_w2[aw:aw-1], rd_gray_w2[aw-2:0]});
    assign wr_en = push && !full;

    always_ff @(posedge pclk or negedge nrst) begin
        if (!nrst) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_en) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    always_ff @(posedge pclk) begin
        if (wr_en) begin
            mem[wr_bin[aw-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge pclk or negedge nrst) begin
        if (!nrst) begin
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    // Sticky until reset, the dropped word is lost
    always_ff @(posedge pclk or negedge nrst) begin
        if (!nrst) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    // Show-ahead read, popped on every cycle with data
    assign empty   = (rd_gray == wr_gray_r2);
    assign rd_word = mem[rd_bin[aw-1:0]];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (!empty) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    // Each binary bit is the XOR of the Gray bits at and above it
    always_comb begin
        for (int i = 0; i <= aw; i++) begin
            rd_bin_w[i] = ^(rd_gray_w2 >> i);
            wr_bin_r[i] = ^(wr_gray_r2 >> i);
        end
    end

    assign wr_used = wr_bin - rd_bin_w;
    assign rd_used = wr_bin_r - rd_bin;

    // Writer stays within one depth of the read pointer it sees
    wr_hold_full: assert property (@(posedge pclk) disable iff (!nrst)
        wr_used <= depth_cnt)
        else $error("write pointer moved while full");

    // Reader never passes the write pointer it sees
    rd_hold_empty: assert property (@(posedge clk) disable iff (!nrst)
        rd_used <= depth_cnt)
        else $error("read pointer moved while empty");

endmodule

`default_nettype wire

// File: rgb_logic.sv
`timescale 1ns/1ps
`default_nettype none

module rgb_logic (
    input  logic               clk,
    input  logic               nrst,

    input  cam_pkg::cam_word_t word,
    input  logic               empty,

    // Level from the control side, taken at frame start only
    input  logic               rgb_enable,

    output cam_pkg::pixel_t    pix
);

    logic       vsync_r;
    logic       en_frame;
    logic       en_now;
    logic       consume;
    logic       frame_start;
    logic       visible;

    // Position of the next visible word
    logic [2:0] col_cnt;
    logic [3:0] line_cnt;
    logic [2:0] blk_col_cnt;
    logic [1:0] blk_line_cnt;

    // Position of the word consumed now, and the one after it
    logic [2:0] cur_col;
    logic [3:0] cur_line;
    logic [2:0] cur_blk_col;
    logic [1:0] cur_blk_line;
    logic [2:0] nxt_col;
    logic [3:0] nxt_line;
    logic [2:0] nxt_blk_col;
    logic [1:0] nxt_blk_line;

    assign consume     = !empty;
    assign frame_start = consume && word.vsync && !vsync_r;
    assign visible     = consume && word.vsync && word.hsync;

    // The frame-start word already sees the new enable
    assign en_now = frame_start ? rgb_enable : en_frame;

    always_comb begin
        cur_col      = frame_start ? '0 : col_cnt;
        cur_line     = frame_start ? '0 : line_cnt;
        cur_blk_col  = frame_start ? '0 : blk_col_cnt;
        cur_blk_line = frame_start ? '0 : blk_line_cnt;

        nxt_col      = cur_col;
        nxt_line     = cur_line;
        nxt_blk_col  = cur_blk_col;
        nxt_blk_line = cur_blk_line;

        // Columns, then µblock columns, then lines, then µblock lines
        if (visible) begin
            nxt_col = cur_col + 3'd1;
            if (cur_col == 3'(cam_pkg::pix_cols_per_block - 1)) begin
                nxt_col     = '0;
                nxt_blk_col = cur_blk_col + 3'd1;
                if (cur_blk_col == 3'(cam_pkg::block_cols - 1)) begin
                    nxt_blk_col = '0;
                    nxt_line    = cur_line + 4'd1;
                    if (cur_line == 4'(cam_pkg::pix_lines_per_block - 1)) begin
                        nxt_line     = '0;
                        nxt_blk_line = cur_blk_line + 2'd1;
                        if (cur_blk_line == 2'(cam_pkg::block_lines - 1)) begin
                            nxt_blk_line = '0;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            vsync_r      <= 1'b0;
            en_frame     <= 1'b0;
            col_cnt      <= '0;
            line_cnt     <= '0;
            blk_col_cnt  <= '0;
            blk_line_cnt <= '0;
        end else if (consume) begin
            vsync_r      <= word.vsync;
            en_frame     <= en_now;
            col_cnt      <= nxt_col;
            line_cnt     <= nxt_line;
            blk_col_cnt  <= nxt_blk_col;
            blk_line_cnt <= nxt_blk_line;
        end
    end

    // Valid lasts one cycle per consumed visible word
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pix <= '0;
        end else begin
            pix.valid <= visible && en_now;
            if (consume) begin
                // First and last bytes trade places
                pix.data       <= {word.rgb[7:0], word.rgb[15:8], word.rgb[23:16]};
                pix.pixel_col  <= cur_col;
                pix.pixel_line <= cur_line;
                pix.block_col  <= cur_blk_col;
                pix.block_line <= cur_blk_line;
            end
        end
    end

    coord_in_grid: assert property (@(posedge clk) disable iff (!nrst)
        pix.valid |-> (pix.block_col <= 3'(cam_pkg::block_cols - 1)) &&
                      (pix.block_line <= 2'(cam_pkg::block_lines - 1)))
        else $error("pixel tagged outside the µblock grid");

endmodule

`default_nettype wire

// File: block_averager.sv
`timescale 1ns/1ps
`default_nettype none

module block_averager (
    input  logic                clk,
    input  logic                nrst,

    input  cam_pkg::pixel_t     pix,

    output cam_pkg::block_avg_t block_out,
    output logic                block_valid
);

    localparam int avg_shift = $clog2(cam_pkg::pixels_per_block);
    // 128 times 255 fits in 15 bits
    localparam int sum_w     = 8 + avg_shift;

    // One accumulator per µblock column, three channel sums each
    logic [2:0][sum_w-1:0] acc [cam_pkg::block_cols];
    logic [2:0][sum_w-1:0] sum;

    logic take;
    logic first_pix;
    logic last_pix;

    assign take      = pix.valid && (pix.block_col < 3'(cam_pkg::block_cols));
    assign first_pix = (pix.pixel_col == '0) && (pix.pixel_line == '0);
    assign last_pix  = (pix.pixel_col == 3'(cam_pkg::pix_cols_per_block - 1)) &&
                       (pix.pixel_line == 4'(cam_pkg::pix_lines_per_block - 1));

    // A µblock's first pixel starts a fresh sum
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            if (first_pix) begin
                sum[c] = sum_w'(pix.data[c*8 +: 8]);
            end else begin
                sum[c] = acc[pix.block_col][c] + sum_w'(pix.data[c*8 +: 8]);
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int b = 0; b < cam_pkg::block_cols; b++) begin
                acc[b] <= '0;
            end
            block_valid <= 1'b0;
        end else begin
            block_valid <= take && last_pix;
            if (take) begin
                // Cleared once the µblock has been reported
                acc[pix.block_col] <= last_pix ? '0 : sum;
            end
        end
    end

    // Held until the next finished µblock
    always_ff @(posedge clk) begin
        if (take && last_pix) begin
            for (int c = 0; c < 3; c++) begin
                block_out.avg[c*8 +: 8] <= sum[c][avg_shift +: 8];
            end
            block_out.block_col  <= pix.block_col;
            block_out.block_line <= pix.block_line;
        end
    end

    // A finished µblock is always followed by a new first column
    single_pulse: assert property (@(posedge clk) disable iff (!nrst)
        block_valid |=> !block_valid)
        else $error("block_valid high on two cycles in a row");

endmodule

`default_nettype wire

// File: cam_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_capture_top #(
    parameter int fifo_depth = 16
) (
    input  logic                clk,
    input  logic                pclk,
    input  logic                nrst,

    // Sensor side, on pclk
    input  logic                cam_push,
    input  cam_pkg::cam_word_t  cam_in,

    input  logic                rgb_enable,

    output cam_pkg::block_avg_t block_out,
    output logic                block_valid,
    output logic                overflow
);

    cam_pkg::cam_word_t fifo_word;
    logic               fifo_empty;
    cam_pkg::pixel_t    pix;

    pixel_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .pclk     (pclk),
        .clk      (clk),
        .nrst     (nrst),
        .push     (cam_push),
        .wr_word  (cam_in),
        .rd_word  (fifo_word),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    rgb_logic u_rgb (
        .clk        (clk),
        .nrst       (nrst),
        .word       (fifo_word),
        .empty      (fifo_empty),
        .rgb_enable (rgb_enable),
        .pix        (pix)
    );

    block_averager u_avg (
        .clk         (clk),
        .nrst        (nrst),
        .pix         (pix),
        .block_out   (block_out),
        .block_valid (block_valid)
    );

endmodule

`default_nettype wire

// File: tb_cam_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cam_capture;

    localparam int n_frames    = 8;
    localparam int img_w       = cam_pkg::pix_cols_per_block * cam_pkg::block_cols;
    localparam int img_h       = cam_pkg::pix_lines_per_block * cam_pkg::block_lines;
    localparam int n_blocks    = cam_pkg::block_cols * cam_pkg::block_lines;
    localparam int blank_words = 2;

    localparam logic [1:0] k_const = 2'd0;
    localparam logic [1:0] k_block = 2'd1;
    localparam logic [1:0] k_rand  = 2'd2;

    // One row of the frame table
    typedef struct packed {
        logic       en;
        logic [1:0] kind;
        logic       gap;
        logic       blank;
        logic       toggle;
    } frame_t;

    logic                clk;
    logic                pclk;
    logic                nrst;
    logic                cam_push;
    cam_pkg::cam_word_t  cam_in;
    logic                rgb_enable;
    cam_pkg::block_avg_t block_out;
    logic                block_valid;
    logic                overflow;

    frame_t              frame_tab [n_frames];
    logic [23:0]         frame_px [img_w * img_h];
    cam_pkg::block_avg_t exp_q [$];
    logic [31:0]         lfsr;
    int                  pushed_cnt;
    int                  consumed_cnt;
    int                  recv_cnt;
    int                  err_cnt;
    int                  cycle_cnt;
    int                  cycle_limit;

    cam_capture_top #(
        .fifo_depth (16)
    ) UUT (
        .clk         (clk),
        .pclk        (pclk),
        .nrst        (nrst),
        .cam_push    (cam_push),
        .cam_in      (cam_in),
        .rgb_enable  (rgb_enable),
        .block_out   (block_out),
        .block_valid (block_valid),
        .overflow    (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Camera clock, slower than clk
    initial begin
        pclk = 1'b0;
        forever #15 pclk = ~pclk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [23:0] block_colour(input int bc, input int bl);
        return {8'(bl * 70 + bc * 13), 8'(200 - bc * 31), 8'(bl * 5 + 17)};
    endfunction

    // Worst case pclk slots of the table, gap cycles counted as words
    function automatic int table_slots();
        int words;
        int total;
        total = 0;
        for (int i = 0; i < n_frames; i++) begin
            words = 3 + img_w * img_h + (frame_tab[i].blank ? img_h * blank_words : 0);
            total += frame_tab[i].gap ? words * 4 : words;
        end
        return total;
    endfunction

    task automatic fill_frame(input frame_t f, input int idx);
        for (int y = 0; y < img_h; y++) begin
            for (int x = 0; x < img_w; x++) begin
                case (f.kind)
                    k_const: frame_px[y * img_w + x] = 24'h3ca50f + 24'(idx);
                    k_block: frame_px[y * img_w + x] =
                        block_colour(x / cam_pkg::pix_cols_per_block,
                                     y / cam_pkg::pix_lines_per_block);
                    default: frame_px[y * img_w + x] = 24'(take_bits(24));
                endcase
            end
        end
    endtask

    // Byte swap, per-channel sum of each µblock, truncated mean
    task automatic model_frame();
        int                  sums [n_blocks][3];
        logic [23:0]         p;
        logic [23:0]         sw;
        int                  b;
        cam_pkg::block_avg_t e;
        for (int i = 0; i < n_blocks; i++) begin
            for (int c = 0; c < 3; c++) begin
                sums[i][c] = 0;
            end
        end
        for (int y = 0; y < img_h; y++) begin
            for (int x = 0; x < img_w; x++) begin
                p  = frame_px[y * img_w + x];
                sw = {p[7:0], p[15:8], p[23:16]};
                b  = (y / cam_pkg::pix_lines_per_block) * cam_pkg::block_cols +
                     x / cam_pkg::pix_cols_per_block;
                for (int c = 0; c < 3; c++) begin
                    sums[b][c] += int'(sw[c*8 +: 8]);
                end
            end
        end
        // Results come out in raster order of the µblocks
        for (int bl = 0; bl < cam_pkg::block_lines; bl++) begin
            for (int bc = 0; bc < cam_pkg::block_cols; bc++) begin
                b = bl * cam_pkg::block_cols + bc;
                for (int c = 0; c < 3; c++) begin
                    e.avg[c*8 +: 8] = 8'(sums[b][c] / cam_pkg::pixels_per_block);
                end
                e.block_col  = 3'(bc);
                e.block_line = 2'(bl);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic check_block(input cam_pkg::block_avg_t got, input cam_pkg::block_avg_t want);
        if (got !== want) begin
            $display("[ERROR] %0t block_out got %h (col %0d line %0d) expected %h (col %0d line %0d)",
                     $time, got.avg, got.block_col, got.block_line,
                     want.avg, want.block_col, want.block_line);
            err_cnt++;
        end
    endtask

    task automatic check_overflow(input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] %0t overflow got %b expected %b", $time, got, want);
            err_cnt++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge pclk);
        #2;
        cam_push = 1'b0;
    endtask

    task automatic send_word(input logic [23:0] rgb, input logic hs, input logic vs,
                             input logic gap);
        int n;
        @(posedge pclk);
        #2;
        cam_push = 1'b1;
        cam_in   = '{rgb: rgb, hsync: hs, vsync: vs};
        pushed_cnt++;
        if (gap) begin
            n = int'(take_bits(2));
            repeat (n) idle_cycle();
        end
    endtask

    task automatic drive_frame(input frame_t f);
        idle_cycle();
        rgb_enable = f.en;
        // Vsync low ahead of the frame start
        send_word(24'h0, 1'b0, 1'b0, f.gap);
        send_word(24'h0, 1'b0, 1'b0, f.gap);
        for (int y = 0; y < img_h; y++) begin
            for (int x = 0; x < img_w; x++) begin
                // Must not reach this frame's validity
                if (f.toggle && y == img_h / 2 && x == 0) begin
                    rgb_enable = ~rgb_enable;
                end
                send_word(frame_px[y * img_w + x], 1'b1, 1'b1, f.gap);
            end
            if (f.blank) begin
                repeat (blank_words) send_word(24'h0, 1'b0, 1'b1, f.gap);
            end
        end
        idle_cycle();
    endtask

    // Then one edge each for rgb_logic and the averager
    task automatic wait_drain();
        while (consumed_cnt != pushed_cnt) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    // Words popped by the DUT
    always @(negedge clk) begin
        if (nrst === 1'b1 && !UUT.fifo_empty) begin
            consumed_cnt++;
        end
    end

    always @(negedge clk) begin
        if (nrst === 1'b1 && block_valid) begin
            recv_cnt++;
            if (exp_q.size() == 0) begin
                $display("%0t: block_valid pulsed while no average was expected", $time);
                err_cnt++;
            end else begin
                check_block(block_out, exp_q.pop_front());
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        wait (nrst === 1'b1);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run went past %0d clock cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        int errs_before;
        int exp_n;
        nrst         = 1'b0;
        cam_push     = 1'b0;
        cam_in       = '0;
        rgb_enable   = 1'b0;
        lfsr         = 32'h4c0a;
        pushed_cnt   = 0;
        consumed_cnt = 0;
        recv_cnt     = 0;
        err_cnt      = 0;
        // enable, pattern, gap, blanking, mid-frame toggle
        frame_tab[0] = '{1'b1, k_const, 1'b0, 1'b0, 1'b0};
        frame_tab[1] = '{1'b1, k_block, 1'b0, 1'b0, 1'b0};
        frame_tab[2] = '{1'b1, k_rand,  1'b0, 1'b0, 1'b0};
        frame_tab[3] = '{1'b0, k_block, 1'b0, 1'b0, 1'b1};
        frame_tab[4] = '{1'b1, k_block, 1'b1, 1'b1, 1'b0};
        frame_tab[5] = '{1'b1, k_rand,  1'b0, 1'b1, 1'b1};
        frame_tab[6] = '{1'b1, k_const, 1'b1, 1'b0, 1'b0};
        frame_tab[7] = '{1'b0, k_rand,  1'b1, 1'b0, 1'b0};
        cycle_limit  = 3 * table_slots() + 200;

        repeat (8) @(posedge clk);
        #2;
        nrst = 1'b1;

        for (int i = 0; i < n_frames; i++) begin
            errs_before = err_cnt;
            recv_cnt    = 0;
            exp_n       = 0;
            fill_frame(frame_tab[i], i);
            if (frame_tab[i].en) begin
                model_frame();
                exp_n = n_blocks;
            end
            drive_frame(frame_tab[i]);
            wait_drain();
            if (recv_cnt != exp_n) begin
                $display("Frame %0d gave %0d averages instead of %0d", i, recv_cnt, exp_n);
                err_cnt++;
            end
            check_overflow(overflow, 1'b0);
            $display("frame %0d: enable %0b pattern %0d gap %0b blank %0b, %0d averages, %0d errors",
                     i, frame_tab[i].en, frame_tab[i].kind, frame_tab[i].gap,
                     frame_tab[i].blank, recv_cnt, err_cnt - errs_before);
        end

        $display("%0d frames run, %0d errors", n_frames, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
cam_pkg.sv
pixel_fifo.sv
rgb_logic.sv
block_averager.sv
cam_capture_top.sv
tb_cam_capture.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cam_capture
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
